// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module fftCtrlTb -Mdir obj_dir -o fftCtrlTb
	./obj_dir/fftCtrlTb | tee sim.log
	@if grep -q "Something failed" sim.log || ! grep -q "Everything OK" sim.log; then \
		echo "Simulation failed"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir sim.log

// File: bench/fftCtrlGolden.txt
// Run record: 0 <idle cycles before start> 0 0 0 0 0
// Point record: 1 <phase 1..4> <cycle in phase> <bank> <ioBuf addr> <fsc addr> <exponent>
// A record starting with f ends the list, all words hex
0 4   0   0 0   0   0
1 1   64  3 64  0   0
1 2   5   2 168 80  0
1 2   12c 6 64  a4  774
1 2   207 0 78  ff  0
1 3   3   7 7   4   0
1 3   c8  4 c1  c8  0
1 4   4d  5 171 0   0
0 2   0   0 0   0   0
1 1   0   0 0   0   0
1 2   7   1 b8  40  0
1 2   64  7 1a1 1e1 29f
1 2   206 3 170 1f7 7a1
1 4   1ff 2 1ef 0   0
f 0   0   0 0   0   0

// File: bench/fftCtrlTb.sv
`timescale 1ns/100ps
`default_nettype none

`include "fftCtrl_settings.svh"

module fftCtrlTb import fftCtrlPkg::*; ();

    localparam int runCycles = 2 * `FFT_POINTS + 2 * (`FFT_POINTS + `PIPE_DELAY) + `FLUSH_CYCLES;
    localparam int goldMax   = 64;  // Records of 7 words

    logic         CLK;
    logic         RSTn;
    logic         start;
    logic         done;
    memPort_t     ioBuf;
    memPort_t     fsc;
    muxSel_t      muxSel;
    twiddleExps_t twiddle;

    logic [15:0]  golden [0:goldMax*7-1];
    logic [31:0]  rngState;
    int           errors, checks, cycles, limit, curRun, ptHits;
    fftPhase_t    mPhase;      // Reference model
    int           mIdx, mPrevRot;

    fftCtrlTop fftCtrlTop_i (
        .CLK(CLK), .RSTn(RSTn), .start(start), .done(done),
        .ioBuf(ioBuf), .fsc(fsc), .muxSel(muxSel), .twiddle(twiddle)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int digitSum(input int v);
        return ((v / 64) + (v / 8) % 8 + v % 8) % 8;
    endfunction

    function automatic int phaseLength(input fftPhase_t p);
        case (p)
            phInput, phOutput: return `FFT_POINTS;
            phIter1, phIter2:  return `FFT_POINTS + `PIPE_DELAY;
            default:           return 1;  // Flush cycles
        endcase
    endfunction

    task automatic checkValue(input string name, input int got, input int expected);
        checks++;
        if (got != expected) begin
            errors++;
            $display("FAILED at %0t: %s = %0d, expected %0d", $time, name, got, expected);
        end
    endtask

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    // Checks every cycle at the falling edge, then steps the model
    always @(negedge CLK) begin
        int  rd, wr, ex, rdRot, wrRot, rIdx, wIdx, rdA, wrA, ioExp, fscExp, tw, runNo, pb;
        bit  it1, it2;
        cycles++;
        if (cycles > limit) begin
            $display("Timeout: the runs did not finish within %0d cycles", limit);
            $display("Something failed");
            $finish;
        end else begin
            it1   = (mPhase == phIter1);
            it2   = (mPhase == phIter2);
            rd    = (it1 || it2) ? mIdx % 512 : mIdx;
            wr    = ((it1 || it2) && mIdx >= `PIPE_DELAY) ? mIdx - `PIPE_DELAY : 0;
            ex    = ((it1 || it2) && mIdx >= `EXP_DELAY) ? (mIdx - `EXP_DELAY) % 512 : 0;
            rdRot = digitSum(rd);
            wrRot = digitSum(wr);
            checkValue("done", done, mPhase == phOutput);
            checkValue("ioBuf.we", ioBuf.we, mPhase == phInput || it2);
            checkValue("fsc.we", fsc.we, it1);
            checkValue("selExtn", muxSel.selExtn, mPhase != phInput);
            checkValue("selItr", muxSel.selItr, it2);
            checkValue("hrmfSel", muxSel.hrmfSel, (it1 || it2) ? (rd + 7) % 8 : 0);
            checkValue("permWrite", muxSel.permWrite, (mPhase == phInput) ? rdRot : wrRot);
            checkValue("permRead", muxSel.permRead, mPrevRot);
            for (int b = 0; b < `NUM_BANKS; b++) begin
                rIdx = (b + 8 - rdRot) % 8;
                wIdx = (b + 8 - wrRot) % 8;
                if (it1) begin
                    rdA = rIdx * 64 + (rd % 8) * 8 + rd / 64;
                    wrA = wIdx * 64 + (wr % 8) * 8 + wr / 64;
                end else begin
                    rdA = (rd / 8) * 8 + rIdx;
                    wrA = (wr / 8) * 8 + wIdx;
                end
                case (mPhase)
                    phInput:  ioExp = rd;
                    phIter1:  ioExp = rdA;
                    phIter2:  ioExp = wrA;
                    phOutput: ioExp = (rd % 8) * 64 + rIdx * 8 + rd / 64;
                    default:  ioExp = 0;
                endcase
                fscExp = it1 ? wrA : (it2 ? rdA : 0);
                tw     = it1 ? ((ex % 8 + 8 * b) * (ex / 8)) % 4096 : 0;
                checkValue($sformatf("ioBuf.addr[%0d]", b), ioBuf.addr[b], ioExp);
                checkValue($sformatf("fsc.addr[%0d]", b), fsc.addr[b], fscExp);
                checkValue($sformatf("twiddle[%0d]", b), twiddle[b], tw);
            end
            // Sampled points of the current run
            runNo = -1;
            for (int j = 0; j < goldMax && golden[j*7] != 16'hf; j++) begin
                if (golden[j*7] == 16'h0)
                    runNo++;
                else if (runNo == curRun && golden[j*7+1] == mPhase
                         && golden[j*7+2] == mIdx) begin
                    pb = golden[j*7+3];
                    checkValue("golden ioBuf.addr", ioBuf.addr[pb], golden[j*7+4]);
                    checkValue("golden fsc.addr", fsc.addr[pb], golden[j*7+5]);
                    checkValue("golden twiddle", twiddle[pb], golden[j*7+6]);
                    ptHits++;
                end
            end
            mPrevRot = rdRot;
            if (!RSTn) begin
                mPhase = phIdle;
                mIdx   = 0;
            end else if (mPhase == phIdle) begin
                mIdx = 0;
                if (start)
                    mPhase = phInput;
            end else begin
                mIdx++;
                if (mIdx == phaseLength(mPhase)) begin
                    mPhase = fftPhase_t'(mPhase + 1);  // Flush2 wraps to idle
                    mIdx   = 0;
                end
            end
        end
    end

    initial begin
        int gaps[$];
        int pts[$];
        int gapSum, gap, errBefore, hitsBefore, doneCycles;
        start    = 1'b0;
        RSTn     = 1'b0;
        errors   = 0;
        checks   = 0;
        cycles   = 0;
        ptHits   = 0;
        curRun   = 0;
        mPhase   = phIdle;
        mIdx     = 0;
        mPrevRot = 0;
        rngState = 32'hbc46_db72;
        gapSum   = 0;
        $readmemh("bench/fftCtrlGolden.txt", golden);
        for (int j = 0; j < goldMax && golden[j*7] != 16'hf; j++) begin
            if (golden[j*7] == 16'h0) begin
                gaps.push_back(golden[j*7+1]);
                pts.push_back(0);
                gapSum += golden[j*7+1];
            end else if (pts.size() > 0) begin
                pts[pts.size()-1] = pts[pts.size()-1] + 1;
            end
        end
        limit = 5 + 10 + gapSum + gaps.size() * (runCycles + 16) + 64;
        if (gaps.size() == 0) begin
            errors++;
            $display("The golden file holds no runs");
        end
        errBefore = errors;
        repeat (5) @(posedge CLK);
        #1 RSTn = 1'b1;
        repeat (10) @(posedge CLK);
        $display("Test reset and idle: %0d errors", errors - errBefore);
        foreach (gaps[r]) begin
            errBefore  = errors;
            hitsBefore = ptHits;
            rngState   = xorshift(rngState);
            gap        = gaps[r] + rngState[2:0];
            repeat (gap) @(posedge CLK);
            curRun = r;
            @(posedge CLK);
            #1 start = 1'b1;
            @(posedge CLK);
            #1 start = 1'b0;
            repeat (700) @(posedge CLK);
            #1 start = 1'b1;  // Lands in iter1
            @(posedge CLK);
            #1 start = 1'b0;
            while (!done) begin
                @(posedge CLK);
                #1;
            end
            doneCycles = 0;
            while (done) begin
                doneCycles++;
                @(posedge CLK);
                #1;
            end
            checkValue("done cycles", doneCycles, `FFT_POINTS);
            repeat (`FLUSH_CYCLES) @(posedge CLK);
            checkValue("golden points hit", ptHits - hitsBefore, pts[r]);
            $display("Test run %0d: %0d golden points, %0d errors",
                     r, ptHits - hitsBefore, errors - errBefore);
        end
        @(posedge CLK);
        #1;
        $display("Checks: %0d, errors: %0d, cycles: %0d", checks, errors, cycles);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+include
logic/fftCtrlPkg.sv
logic/fftSeqCtrl.sv
logic/bankRotation.sv
logic/bankAddrGen.sv
logic/twiddleExpGen.sv
logic/fftCtrlTop.sv
bench/fftCtrlTb.sv

// File: include/fftCtrl_settings.svh
`ifndef FFTCTRL_SETTINGS_SVH
`define FFTCTRL_SETTINGS_SVH

// Transform size
`define FFT_POINTS    512
`define ADDR_W        9   // Bank address and counter width
`define DIGIT_W       3   // One radix-8 digit
`define NUM_BANKS     8

// Twiddle exponent width
`define EXP_W         12

// Memory schedule
`define PIPE_DELAY    8   // Write counter lag behind reads
`define EXP_DELAY     7   // Exponent counter lag behind reads
`define FLUSH_CYCLES  3

`endif

// File: logic/bankAddrGen.sv
`timescale 1ns/100ps
`default_nettype none

`include "fftCtrl_settings.svh"

module bankAddrGen import fftCtrlPkg::*; (
    input  wire fftPhase_t    phase,
    input  wire [`ADDR_W-1:0] rdCnt,
    input  wire [`ADDR_W-1:0] wrCnt,
    input  wire bankIdx_t     rdIdx,
    input  wire bankIdx_t     wrIdx,
    output bankAddrs_t        ioBufAddr,
    output bankAddrs_t        fscAddr
);

    cntDigits_t r;
    cntDigits_t w;
    bankAddrs_t rdAddr;
    bankAddrs_t wrAddr;

    assign r = rdCnt;
    assign w = wrCnt;

    // Iteration patterns, only selected during iter1 and iter2
    always_comb begin
        for (int b = 0; b < `NUM_BANKS; b++) begin
            if (phase == phIter1) begin
                rdAddr[b] = {rdIdx[b], r.d0, r.d2};
                wrAddr[b] = {wrIdx[b], w.d0, w.d2};
            end else begin
                rdAddr[b] = {r.d2, r.d1, rdIdx[b]};
                wrAddr[b] = {w.d2, w.d1, wrIdx[b]};
            end
        end
    end

    always_comb begin
        for (int b = 0; b < `NUM_BANKS; b++) begin
            case (phase)
                phInput:  ioBufAddr[b] = rdCnt;      // Linear fill
                phIter1:  ioBufAddr[b] = rdAddr[b];
                phIter2:  ioBufAddr[b] = wrAddr[b];
                phOutput: ioBufAddr[b] = {r.d0, rdIdx[b], r.d2}; // Digit reversed
                default:  ioBufAddr[b] = '0;
            endcase
        end
    end

    always_comb begin
        for (int b = 0; b < `NUM_BANKS; b++) begin
            case (phase)
                phIter1: fscAddr[b] = wrAddr[b];
                phIter2: fscAddr[b] = rdAddr[b];
                default: fscAddr[b] = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/bankRotation.sv
`timescale 1ns/100ps
`default_nettype none

`include "fftCtrl_settings.svh"

module bankRotation import fftCtrlPkg::*; (
    input  wire                     CLK,
    input  wire                     RSTn,
    input  wire fftPhase_t          phase,
    input  wire [`ADDR_W-1:0]       rdCnt,
    input  wire [`ADDR_W-1:0]       wrCnt,
    output bankIdx_t                rdIdx,
    output bankIdx_t                wrIdx,
    output logic [`DIGIT_W-1:0]     permWrite,
    output logic [`DIGIT_W-1:0]     permRead
);

    cntDigits_t          rd;
    cntDigits_t          wr;
    logic [`DIGIT_W-1:0] rdRot;
    logic [`DIGIT_W-1:0] wrRot;

    assign rd = rdCnt;
    assign wr = wrCnt;

    // Digit sum, wraps mod 8
    assign rdRot = rd.d2 + rd.d1 + rd.d0;
    assign wrRot = wr.d2 + wr.d1 + wr.d0;

    always_comb begin
        for (int b = 0; b < `NUM_BANKS; b++) begin
            rdIdx[b] = `DIGIT_W'(b) - rdRot;
            wrIdx[b] = `DIGIT_W'(b) - wrRot;
        end
    end

    assign permWrite = (phase == phInput) ? rdRot : wrRot;

    // Aligns with read data one cycle later
    always_ff @(posedge CLK or negedge RSTn) begin
        if (!RSTn)
            permRead <= '0;
        else
            permRead <= rdRot;
    end

    assert property (@(posedge CLK) disable iff (!RSTn)
        $past(phase == phInput) |-> permRead == $past(permWrite));

endmodule

`default_nettype wire

// File: logic/fftCtrlPkg.sv
`default_nettype none

`include "fftCtrl_settings.svh"

package fftCtrlPkg;

    typedef enum logic [2:0] {
        phIdle   = 3'd0,
        phInput  = 3'd1,
        phIter1  = 3'd2,
        phIter2  = 3'd3,
        phOutput = 3'd4,
        phFlush0 = 3'd5,
        phFlush1 = 3'd6,
        phFlush2 = 3'd7
    } fftPhase_t;

    // Counter split into radix-8 digits, high digit first
    typedef struct packed {
        logic [`DIGIT_W-1:0] d2;
        logic [`DIGIT_W-1:0] d1;
        logic [`DIGIT_W-1:0] d0;
    } cntDigits_t;

    typedef logic [`NUM_BANKS-1:0][`ADDR_W-1:0] bankAddrs_t;

    typedef struct packed {
        logic       we;
        bankAddrs_t addr;
    } memPort_t;

    typedef struct packed {
        logic                selExtn;
        logic                selItr;
        logic [`DIGIT_W-1:0] permWrite;
        logic [`DIGIT_W-1:0] permRead;
        logic [`DIGIT_W-1:0] hrmfSel;
    } muxSel_t;

    typedef logic [`NUM_BANKS-1:0][`EXP_W-1:0] twiddleExps_t;

    typedef logic [`NUM_BANKS-1:0][`DIGIT_W-1:0] bankIdx_t;

endpackage

`default_nettype wire

// File: logic/fftCtrlTop.sv
`timescale 1ns/100ps
`default_nettype none

`include "fftCtrl_settings.svh"

module fftCtrlTop import fftCtrlPkg::*; (
    input  wire          CLK,
    input  wire          RSTn,
    input  wire          start,
    output logic         done,
    output memPort_t     ioBuf,
    output memPort_t     fsc,
    output muxSel_t      muxSel,
    output twiddleExps_t twiddle
);

    fftPhase_t           phase;
    logic [`ADDR_W-1:0]  rdCnt, wrCnt, expCnt;
    logic                ioBufWe, fscWe;
    logic                selExtn, selItr;
    logic [`DIGIT_W-1:0] hrmfSel, permWrite, permRead;
    bankIdx_t            rdIdx, wrIdx;
    bankAddrs_t          ioBufAddr, fscAddr;

    fftSeqCtrl fftSeqCtrl_i (
        .CLK(CLK), .RSTn(RSTn), .start(start),
        .phase(phase), .rdCnt(rdCnt), .wrCnt(wrCnt), .expCnt(expCnt),
        .done(done), .ioBufWe(ioBufWe), .fscWe(fscWe),
        .selExtn(selExtn), .selItr(selItr), .hrmfSel(hrmfSel)
    );

    bankRotation bankRotation_i (
        .CLK(CLK), .RSTn(RSTn), .phase(phase), .rdCnt(rdCnt), .wrCnt(wrCnt),
        .rdIdx(rdIdx), .wrIdx(wrIdx), .permWrite(permWrite), .permRead(permRead)
    );

    bankAddrGen bankAddrGen_i (
        .phase(phase), .rdCnt(rdCnt), .wrCnt(wrCnt), .rdIdx(rdIdx), .wrIdx(wrIdx),
        .ioBufAddr(ioBufAddr), .fscAddr(fscAddr)
    );

    twiddleExpGen twiddleExpGen_i (.phase(phase), .expCnt(expCnt), .twiddle(twiddle));

    assign ioBuf  = '{we: ioBufWe, addr: ioBufAddr};
    assign fsc    = '{we: fscWe, addr: fscAddr};
    assign muxSel = '{selExtn: selExtn, selItr: selItr, permWrite: permWrite,
                      permRead: permRead, hrmfSel: hrmfSel};

endmodule

`default_nettype wire

// File: logic/fftSeqCtrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "fftCtrl_settings.svh"

module fftSeqCtrl import fftCtrlPkg::*; (
    input  wire                 CLK,
    input  wire                 RSTn,
    input  wire                 start,
    output fftPhase_t           phase,
    output logic [`ADDR_W-1:0]  rdCnt,
    output logic [`ADDR_W-1:0]  wrCnt,
    output logic [`ADDR_W-1:0]  expCnt,
    output logic                done,
    output logic                ioBufWe,
    output logic                fscWe,
    output logic                selExtn,
    output logic                selItr,
    output logic [`DIGIT_W-1:0] hrmfSel
);

    localparam logic [`ADDR_W-1:0] lastCnt = `ADDR_W'(`FFT_POINTS - 1);

    fftPhase_t nextPhase;
    logic      termCnt;
    logic      busy;

    assign busy = (phase == phIter1) || (phase == phIter2);

    // Terminal count per phase, always set in idle and flush
    always_comb begin
        case (phase)
            phInput, phOutput: termCnt = (rdCnt == lastCnt);
            phIter1, phIter2:  termCnt = (wrCnt == lastCnt);
            default:           termCnt = 1'b1;
        endcase
    end

    always_comb begin
        nextPhase = phase;
        case (phase)
            phIdle:   if (start) nextPhase = phInput;
            phInput:  if (termCnt) nextPhase = phIter1;
            phIter1:  if (termCnt) nextPhase = phIter2;
            phIter2:  if (termCnt) nextPhase = phOutput;
            phOutput: if (termCnt) nextPhase = phFlush0;
            phFlush0: nextPhase = phFlush1;
            phFlush1: nextPhase = phFlush2;
            default:  nextPhase = phIdle;
        endcase
    end

    always_ff @(posedge CLK or negedge RSTn) begin
        if (!RSTn) begin
            phase  <= phIdle;
            rdCnt  <= '0;
            wrCnt  <= '0;
            expCnt <= '0;
        end else begin
            phase <= nextPhase;
            rdCnt <= termCnt ? '0 : rdCnt + 1'b1;
            if (termCnt || !busy)
                wrCnt <= '0;
            else if (wrCnt == '0 && rdCnt < `PIPE_DELAY)
                wrCnt <= '0; // Hold until the pipe fills
            else
                wrCnt <= wrCnt + 1'b1;
            if (termCnt || !busy)
                expCnt <= '0;
            else if (expCnt == '0 && rdCnt < `EXP_DELAY)
                expCnt <= '0;
            else
                expCnt <= expCnt + 1'b1;
        end
    end

    assign done    = (phase == phOutput);
    assign ioBufWe = (phase == phInput) || (phase == phIter2);
    assign fscWe   = (phase == phIter1);
    assign selExtn = (phase != phInput);  // External data only while filling
    assign selItr  = (phase == phIter2);
    assign hrmfSel = busy ? rdCnt[`DIGIT_W-1:0] - `DIGIT_W'(1) : '0;

    assert property (@(posedge CLK) disable iff (!RSTn)
        $changed({ioBufWe, fscWe}) |-> $past(termCnt));
    assert property (@(posedge CLK) disable iff (!RSTn)
        $rose(done) |-> $past(phase == phIter2 && termCnt));
    assert property (@(posedge CLK) disable iff (!RSTn)
        (start && phase != phIdle && phase != phInput) |=> phase != phInput);
    assert property (@(posedge CLK) disable iff (!RSTn)
        (phase == phOutput && termCnt) |-> ##(`FLUSH_CYCLES + 1) phase == phIdle);

endmodule

`default_nettype wire

// File: logic/twiddleExpGen.sv
`timescale 1ns/100ps
`default_nettype none

`include "fftCtrl_settings.svh"

module twiddleExpGen import fftCtrlPkg::*; (
    input  wire fftPhase_t    phase,
    input  wire [`ADDR_W-1:0] expCnt,
    output twiddleExps_t      twiddle
);

    cntDigits_t        e;
    logic [`EXP_W-1:0] n1, n2, n3, n4, n5, n6, n7, n8;
    logic [`EXP_W-1:0] exp0;
    logic [`EXP_W-1:0] acc;

    assign e = expCnt;

    // Base multiples from shifts and adds
    assign n1 = (phase == phIter1) ? {{(`EXP_W - 2*`DIGIT_W){1'b0}}, e.d2, e.d1} : '0;
    assign n2 = n1 << 1;
    assign n3 = n1 + n2;
    assign n4 = n2 << 1;
    assign n5 = n1 + n4;
    assign n6 = n3 << 1;
    assign n7 = n1 + n6;
    assign n8 = n4 << 1;  // Step between banks

    always_comb begin
        case (e.d0)
            3'd1:    exp0 = n1;
            3'd2:    exp0 = n2;
            3'd3:    exp0 = n3;
            3'd4:    exp0 = n4;
            3'd5:    exp0 = n5;
            3'd6:    exp0 = n6;
            3'd7:    exp0 = n7;
            default: exp0 = '0;
        endcase
    end

    always_comb begin
        acc = exp0;
        for (int k = 0; k < `NUM_BANKS; k++) begin
            twiddle[k] = acc;
            acc        = acc + n8;
        end
    end

endmodule

`default_nettype wire
